/* all.f */
vector_alu_pkg.sv
vector_operand_broadcast.sv
vector_alu.sv
vector_mask_merge.sv
vector_exec_unit.sv
tb_vector_exec_unit_properties.sv
tb_vector_exec_unit.sv

/* Makefile */
SIM  := obj_dir/Vtb_vector_exec_unit
SRCS := $(shell cat all.f)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) all.f
	verilator --binary --timing --assert -Wno-fatal -f all.f \
		--top-module tb_vector_exec_unit -Mdir obj_dir

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir

/* tb_vector_exec_unit.sv */
`default_nettype none

module tb_vector_exec_unit
    import vector_alu_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int VLEN     = 64;
    localparam int VLENB    = VLEN / 8;
    localparam int TIMEOUT  = 10;
    localparam int N_RANDOM = 40;

    logic             clk;
    logic             reset_i;
    logic             valid_i;
    vec_op_e          op_i;
    vsew_e            vsew_i;
    opsrc_e           opsrc_i;
    logic [VLEN-1:0]  vs2_i;
    logic [VLEN-1:0]  vs1_i;
    logic [XLEN-1:0]  scalar_i;
    logic [4:0]       imm_i;
    logic [VLEN-1:0]  vd_old_i;
    logic [VLENB-1:0] mask_i;
    logic             vm_i;
    logic             valid_o;
    logic [VLEN-1:0]  result_o;

    typedef struct {
        string            name;
        vec_op_e          op;
        vsew_e            vsew;
        opsrc_e           opsrc;
        logic [VLEN-1:0]  vs2;
        logic [VLEN-1:0]  vs1;
        logic [XLEN-1:0]  scalar;
        logic [4:0]       imm;
        logic [VLEN-1:0]  vd_old;
        logic [VLENB-1:0] mask;
        logic             vm;
        logic [VLEN-1:0]  expected;
    } row_t;

    row_t rows_q[$];
    int   issue_q[$];
    int   cycle = 0;

    vector_exec_unit #(.VLEN(VLEN)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic logic [VLEN-1:0] ref_result(row_t r);
        int              ew;
        logic [63:0]     emask;
        longint          ua;
        longint          ub;
        longint          sa;
        longint          sb;
        longint          res;
        logic [VLEN-1:0] out;
        ew    = 8 << int'(r.vsew);
        emask = (64'd1 << ew) - 64'd1;
        out   = r.vd_old;
        for (int i = 0; i < VLEN / ew; i++) begin
            ua = longint'((r.vs2 >> (i * ew)) & emask);
            case (r.opsrc)
                SRC_VV:  ub = longint'((r.vs1 >> (i * ew)) & emask);
                SRC_VX:  ub = longint'(64'(r.scalar) & emask);
                default: ub = longint'({{59{r.imm[4]}}, r.imm} & emask);
            endcase
            // Signed views of both elements
            sa = ua[ew-1] ? (ua | longint'(~emask)) : ua;
            sb = ub[ew-1] ? (ub | longint'(~emask)) : ub;
            case (r.op)
                vadd:    res = ua + ub;
                vsub:    res = ua - ub;
                vrsub:   res = ub - ua;
                vand:    res = ua & ub;
                vor:     res = ua | ub;
                vxor:    res = ua ^ ub;
                vsll:    res = ua << (ub % ew);
                vsrl:    res = ua >> (ub % ew);
                vsra:    res = sa >>> (ub % ew);
                vmin:    res = (sa < sb) ? ua : ub;
                vminu:   res = (ua < ub) ? ua : ub;
                vmax:    res = (sa > sb) ? ua : ub;
                vmaxu:   res = (ua > ub) ? ua : ub;
                vmul:    res = sa * sb;
                vmulh:   res = (sa * sb) >>> ew;
                vmulhu:  res = (ua * ub) >> ew;
                default: res = (sa * ub) >>> ew;
            endcase
            if (r.vm || r.mask[i]) begin
                out = (out & ~(emask << (i * ew))) | ((64'(res) & emask) << (i * ew));
            end
        end
        return out;
    endfunction

    ////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////

    function automatic void add_row(string name, vec_op_e op, vsew_e sew, opsrc_e src,
                                    logic [63:0] vs2, logic [63:0] vs1, logic [31:0] scalar,
                                    logic [4:0] imm, logic [63:0] vd_old, logic [7:0] mask,
                                    logic vm, logic [63:0] expected);
        row_t r;
        r = '{name, op, sew, src, vs2, vs1, scalar, imm, vd_old, mask, vm, expected};
        rows_q.push_back(r);
    endfunction

    // Unmasked vector-vector row
    function automatic void add_vv(string name, vec_op_e op, vsew_e sew, logic [63:0] vs2,
                                   logic [63:0] vs1, logic [63:0] expected);
        add_row(name, op, sew, SRC_VV, vs2, vs1, 32'h0, 5'h0, 64'h0, 8'h0, 1'b1, expected);
    endfunction

    function automatic void build_table();
        add_vv("add_ew8_wrap", vadd, EW8, 64'h01FF, 64'h0001, 64'h0100);
        add_vv("sub_ew16", vsub, EW16, 64'h0001_0000_8000_0005,
               64'h0002_0001_0001_0003, 64'hFFFF_FFFF_7FFF_0002);
        add_vv("rsub_ew32", vrsub, EW32, 64'h0000_0001_0000_0010, 64'h30,
               64'hFFFF_FFFF_0000_0020);
        add_vv("xor_ew8", vxor, EW8, 64'hFF00_FF00_1234_5678,
               64'h0F0F_0F0F_FFFF_0000, 64'hF00F_F00F_EDCB_5678);
        add_vv("sll_ew8", vsll, EW8, 64'h0101_0101_0101_0101, 64'h0700_0309,
               64'h0101_0101_8001_0802);
        add_vv("sra_ew16", vsra, EW16, 64'h8000_8000_4000_F000,
               64'h0000_0011_0004_0004, 64'h8000_C000_0400_FF00);
        add_vv("srl_ew32", vsrl, EW32, 64'h8000_0000_8000_0000,
               64'h0000_0021_0000_001F, 64'h4000_0000_0000_0001);
        add_vv("min_ew8", vmin, EW8, 64'h80, 64'h01, 64'h80);
        add_vv("minu_ew8", vminu, EW8, 64'h80, 64'h01, 64'h01);
        add_vv("max_ew8", vmax, EW8, 64'h80, 64'h01, 64'h01);
        add_vv("maxu_ew8", vmaxu, EW8, 64'h80, 64'h01, 64'h80);
        add_vv("mul_ew16", vmul, EW16, 64'hFFFF_0100, 64'h0002_0100, 64'hFFFE_0000);
        add_vv("mulh_ew8", vmulh, EW8, 64'h80FF, 64'h02FF, 64'hFF00);
        add_vv("mulhu_ew8", vmulhu, EW8, 64'h80FF, 64'h02FF, 64'h01FE);
        add_vv("mulhsu_ew8", vmulhsu, EW8, 64'h80FF, 64'h02FF, 64'hFFFF);
        add_vv("mulh_ew32", vmulh, EW32, 64'h8000_0000, 64'h8000_0000, 64'h4000_0000);
        add_row("vx_add_ew16", vadd, EW16, SRC_VX, 64'h0001_0002_0003_0004, 64'h0,
                32'hABCD_0010, 5'h0, 64'h0, 8'h0, 1'b1, 64'h0011_0012_0013_0014);
        add_row("vi_add_m1_ew8", vadd, EW8, SRC_VI, 64'h0001_0203_0405_0607, 64'h0,
                32'h0, 5'h1F, 64'h0, 8'h0, 1'b1, 64'hFF00_0102_0304_0506);
        add_row("vi_and_ew32", vand, EW32, SRC_VI, 64'h1234_5678_FFFF_FFFF, 64'h0,
                32'h0, 5'h0F, 64'h0, 8'h0, 1'b1, 64'h0000_0008_0000_000F);
        add_row("mask_ew8", vadd, EW8, SRC_VV, 64'h0101_0101_0101_0101,
                64'h0101_0101_0101_0101, 32'h0, 5'h0, 64'hAAAA_AAAA_AAAA_AAAA, 8'hA5,
                1'b0, 64'h02AA_02AA_AA02_AA02);
        // Mask bits above the element count are ignored
        add_row("mask_ew32", vor, EW32, SRC_VV, 64'h0, 64'h1111_1111_2222_2222, 32'h0,
                5'h0, 64'h5555_5555_6666_6666, 8'hFE, 1'b0, 64'h1111_1111_6666_6666);
    endfunction

    function automatic void add_random_rows();
        row_t r;
        for (int k = 0; k < N_RANDOM; k++) begin
            r.name     = $sformatf("random_%0d", k);
            r.op       = vec_op_e'($urandom_range(16, 0));
            r.vsew     = vsew_e'($urandom_range(2, 0));
            r.opsrc    = opsrc_e'($urandom_range(2, 0));
            r.vs2      = {$urandom, $urandom};
            r.vs1      = {$urandom, $urandom};
            r.scalar   = $urandom;
            r.imm      = 5'($urandom);
            r.vd_old   = {$urandom, $urandom};
            r.mask     = 8'($urandom);
            r.vm       = 1'($urandom);
            r.expected = ref_result(r);
            rows_q.push_back(r);
        end
    endfunction

    ////////////////////////////////////////
    // Drive and check
    ////////////////////////////////////////

    task automatic check_value(string name, logic [VLEN-1:0] expected, logic [VLEN-1:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    task automatic wait_for_valid();
        int waited;
        waited = 0;
        @(negedge clk);
        while (valid_o !== 1'b1) begin
            if (waited == TIMEOUT) begin
                $display("valid_o never arrived within %0d cycles", TIMEOUT);
                $display("TEST FAILED");
                $fatal(1, "timeout waiting for valid_o");
            end
            waited++;
            @(negedge clk);
        end
    endtask

    // One row per cycle without gaps
    task automatic drive_rows();
        row_t r;
        foreach (rows_q[k]) begin
            r        = rows_q[k];
            op_i     = r.op;
            vsew_i   = r.vsew;
            opsrc_i  = r.opsrc;
            vs2_i    = r.vs2;
            vs1_i    = r.vs1;
            scalar_i = r.scalar;
            imm_i    = r.imm;
            vd_old_i = r.vd_old;
            mask_i   = r.mask;
            vm_i     = r.vm;
            valid_i  = 1'b1;
            issue_q.push_back(cycle);
            @(posedge clk);
            #1;
        end
        valid_i = 1'b0;
    endtask

    task automatic check_outputs();
        int issued;
        foreach (rows_q[k]) begin
            wait_for_valid();
            issued = issue_q.pop_front();
            check_value(rows_q[k].name, rows_q[k].expected, result_o);
            // Driven after edge n, sampled on n+1, registered out on n+2
            check_value({rows_q[k].name, " latency"}, 64'(issued + 2), 64'(cycle));
        end
    endtask

    initial begin
        void'($urandom(68));
        reset_i  = 1'b1;
        valid_i  = 1'b0;
        op_i     = vadd;
        vsew_i   = EW8;
        opsrc_i  = SRC_VV;
        vs2_i    = '0;
        vs1_i    = '0;
        scalar_i = '0;
        imm_i    = '0;
        vd_old_i = '0;
        mask_i   = '0;
        vm_i     = 1'b1;
        build_table();
        add_random_rows();

        repeat (2) @(posedge clk);
        #1;
        check_value("reset_hold", 64'h0, 64'(valid_o));
        reset_i = 1'b0;

        fork
            drive_rows();
            check_outputs();
        join

        @(negedge clk);
        check_value("valid_drops", 64'h0, 64'(valid_o));
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* tb_vector_exec_unit_properties.sv */
`default_nettype none

module tb_vector_exec_unit_properties #(
    parameter int VLEN = 64
) (
    input logic            clk,
    input logic            reset_i,
    input logic            valid_i,
    input logic            valid_o,
    input logic [VLEN-1:0] result_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // Enough history for two-cycle lookback
    logic [1:0] edges_seen = 2'd0;

    always_ff @(posedge clk) begin
        if (edges_seen != 2'd3) begin
            edges_seen <= edges_seen + 2'd1;
        end
    end

    a_reset_clears_valid: assert property (@(posedge clk) reset_i |=> !valid_o)
        else $error("valid_o high in the cycle after reset");

    a_valid_two_cycles: assert property (@(posedge clk)
        (edges_seen == 2'd3 && !$past(reset_i, 1) && !$past(reset_i, 2))
            |-> (valid_o == $past(valid_i, 2)))
        else $error("valid_o does not follow valid_i by two cycles");

    a_result_known: assert property (@(posedge clk) valid_o |-> !$isunknown(result_o))
        else $error("result_o has unknown bits while valid_o is high");

endmodule

bind vector_exec_unit tb_vector_exec_unit_properties #(.VLEN(VLEN)) u_properties (
    .clk      (clk),
    .reset_i  (reset_i),
    .valid_i  (valid_i),
    .valid_o  (valid_o),
    .result_o (result_o)
);

`default_nettype wire

/* vector_exec_unit.sv */
`default_nettype none

module vector_exec_unit
    import vector_alu_pkg::*;
#(
    parameter  int VLEN  = 64,
    localparam int VLENB = VLEN / 8
) (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             valid_i,
    input  vec_op_e          op_i,
    input  vsew_e            vsew_i,
    input  opsrc_e           opsrc_i,
    input  logic [VLEN-1:0]  vs2_i,
    input  logic [VLEN-1:0]  vs1_i,
    input  logic [XLEN-1:0]  scalar_i,
    input  logic [4:0]       imm_i,
    input  logic [VLEN-1:0]  vd_old_i,
    input  logic [VLENB-1:0] mask_i,
    input  logic             vm_i,
    output logic             valid_o,
    output logic [VLEN-1:0]  result_o
);

    logic [VLEN-1:0] operand_b;
    logic [VLEN-1:0] alu_result;

    vector_operand_broadcast #(.VLEN(VLEN)) u_broadcast (
        .opsrc_i     (opsrc_i),
        .vsew_i      (vsew_i),
        .vs1_i       (vs1_i),
        .scalar_i    (scalar_i),
        .imm_i       (imm_i),
        .operand_b_o (operand_b)
    );

    // Stage 1
    vector_alu #(.VLEN(VLEN)) u_alu (
        .clk              (clk),
        .first_operand_i  (vs2_i),
        .second_operand_i (operand_b),
        .op_i             (op_i),
        .vsew_i           (vsew_i),
        .result_o         (alu_result)
    );

    // Sideband in stage 1 and merge in stage 2
    vector_mask_merge #(.VLEN(VLEN)) u_mask_merge (
        .clk          (clk),
        .reset_i      (reset_i),
        .valid_i      (valid_i),
        .vsew_i       (vsew_i),
        .vm_i         (vm_i),
        .mask_i       (mask_i),
        .vd_old_i     (vd_old_i),
        .alu_result_i (alu_result),
        .valid_o      (valid_o),
        .result_o     (result_o)
    );

endmodule

`default_nettype wire

/* vector_mask_merge.sv */
`default_nettype none

module vector_mask_merge
    import vector_alu_pkg::*;
#(
    parameter  int VLEN  = 64,
    localparam int VLENB = VLEN / 8
) (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             valid_i,
    input  vsew_e            vsew_i,
    input  logic             vm_i,
    input  logic [VLENB-1:0] mask_i,
    input  logic [VLEN-1:0]  vd_old_i,
    input  logic [VLEN-1:0]  alu_result_i,
    output logic             valid_o,
    output logic [VLEN-1:0]  result_o
);

    ////////////////////////////////////////
    // Sideband stage alongside the ALU
    ////////////////////////////////////////

    logic             valid_q;
    vsew_e            vsew_q;
    logic             vm_q;
    logic [VLENB-1:0] mask_q;
    logic [VLEN-1:0]  vd_old_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        vsew_q   <= vsew_i;
        vm_q     <= vm_i;
        mask_q   <= mask_i;
        vd_old_q <= vd_old_i;
    end

    ////////////////////////////////////////
    // Merge and output stage
    ////////////////////////////////////////

    logic [1:0]      sew_shift;
    logic [VLEN-1:0] merged;

    assign sew_shift = sew_log2_bytes(vsew_q);

    // Byte b belongs to element b >> log2(bytes per element)
    always_comb begin
        for (int b = 0; b < VLENB; b++) begin
            merged[8*b+:8] = (vm_q || mask_q[b >> sew_shift]) ? alu_result_i[8*b+:8]
                                                                : vd_old_q[8*b+:8];
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_q;
        end
    end

    always_ff @(posedge clk) begin
        result_o <= merged;
    end

endmodule

`default_nettype wire

/* vector_alu.sv */
`default_nettype none

module vector_alu
    import vector_alu_pkg::*;
#(
    parameter int VLEN = 64
) (
    input  logic            clk,
    input  logic [VLEN-1:0] first_operand_i,
    input  logic [VLEN-1:0] second_operand_i,
    input  vec_op_e         op_i,
    input  vsew_e           vsew_i,
    output logic [VLEN-1:0] result_o
);

    localparam int VLENB = VLEN / 8;

    // Operation decode
    logic       rev_sub;
    logic       do_sub;
    logic       hi_half;
    logic       sign_a;
    logic       sign_b;
    logic [1:0] wsel;

    assign rev_sub = (op_i == vrsub);
    assign do_sub  = op_i inside {vsub, vrsub};
    assign hi_half = (op_i != vmul);
    assign sign_a  = op_i inside {vmulh, vmulhsu};
    assign sign_b  = (op_i == vmulh);
    assign wsel    = sew_log2_bytes(vsew_i);

    ////////////////////////////////////////
    // Logical
    ////////////////////////////////////////

    logic [VLEN-1:0] result_and;
    logic [VLEN-1:0] result_or;
    logic [VLEN-1:0] result_xor;

    assign result_and = first_operand_i & second_operand_i;
    assign result_or  = first_operand_i | second_operand_i;
    assign result_xor = first_operand_i ^ second_operand_i;

    // One entry per element width of 8, 16 and 32 bits
    logic [VLEN-1:0] res_add  [3];
    logic [VLEN-1:0] res_sll  [3];
    logic [VLEN-1:0] res_srl  [3];
    logic [VLEN-1:0] res_sra  [3];
    logic [VLEN-1:0] res_min  [3];
    logic [VLEN-1:0] res_minu [3];
    logic [VLEN-1:0] res_max  [3];
    logic [VLEN-1:0] res_maxu [3];
    logic [VLEN-1:0] res_mul  [3];

    for (genvar w = 0; w < 3; w++) begin : g_width
        localparam int EW = 8 << w;
        localparam int NE = VLENB >> w;
        localparam int SW = 3 + w;

        ////////////////////////////////////////
        // Add / sub / reverse-sub
        ////////////////////////////////////////

        always_comb begin
            for (int i = 0; i < NE; i++) begin
                automatic logic [EW-1:0] a;
                automatic logic [EW-1:0] b;
                a = rev_sub ? second_operand_i[EW*i+:EW] : first_operand_i[EW*i+:EW];
                b = rev_sub ? first_operand_i[EW*i+:EW] : second_operand_i[EW*i+:EW];
                // Negate subtrahend within the element only
                b = do_sub ? (~b + 1'b1) : b;
                res_add[w][EW*i+:EW] = a + b;
            end
        end

        ////////////////////////////////////////
        // Shifts
        ////////////////////////////////////////

        always_comb begin
            for (int i = 0; i < NE; i++) begin
                automatic logic [EW-1:0] a;
                automatic logic [SW-1:0] sh;
                a  = first_operand_i[EW*i+:EW];
                sh = second_operand_i[EW*i+:SW];
                res_sll[w][EW*i+:EW] = a << sh;
                res_srl[w][EW*i+:EW] = a >> sh;
                res_sra[w][EW*i+:EW] = $signed(a) >>> sh;
            end
        end

        ////////////////////////////////////////
        // Min / max
        ////////////////////////////////////////

        always_comb begin
            for (int i = 0; i < NE; i++) begin
                automatic logic [EW-1:0] a;
                automatic logic [EW-1:0] b;
                automatic logic          gt_u;
                automatic logic          gt_s;
                a    = first_operand_i[EW*i+:EW];
                b    = second_operand_i[EW*i+:EW];
                gt_u = a > b;
                gt_s = $signed(a) > $signed(b);
                res_minu[w][EW*i+:EW] = gt_u ? b : a;
                res_min[w][EW*i+:EW]  = gt_s ? b : a;
                res_maxu[w][EW*i+:EW] = gt_u ? a : b;
                res_max[w][EW*i+:EW]  = gt_s ? a : b;
            end
        end

        ////////////////////////////////////////
        // Multiply
        ////////////////////////////////////////

        always_comb begin
            for (int i = 0; i < NE; i++) begin
                automatic logic [EW:0]     a;
                automatic logic [EW:0]     b;
                automatic logic [2*EW+1:0] prod;
                // Extra top bit carries the sign for signed forms
                a    = {sign_a & first_operand_i[EW*i+EW-1], first_operand_i[EW*i+:EW]};
                b    = {sign_b & second_operand_i[EW*i+EW-1], second_operand_i[EW*i+:EW]};
                prod = $signed(a) * $signed(b);
                res_mul[w][EW*i+:EW] = hi_half ? prod[2*EW-1:EW] : prod[EW-1:0];
            end
        end
    end

    ////////////////////////////////////////
    // Result demux
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        unique case (op_i)
            vand:    result_o <= result_and;
            vor:     result_o <= result_or;
            vxor:    result_o <= result_xor;
            vsll:    result_o <= res_sll[wsel];
            vsrl:    result_o <= res_srl[wsel];
            vsra:    result_o <= res_sra[wsel];
            vmin:    result_o <= res_min[wsel];
            vminu:   result_o <= res_minu[wsel];
            vmax:    result_o <= res_max[wsel];
            vmaxu:   result_o <= res_maxu[wsel];
            vmul, vmulh,
            vmulhu, vmulhsu:
                     result_o <= res_mul[wsel];
            default: result_o <= res_add[wsel];
        endcase
    end

endmodule

`default_nettype wire

/* vector_operand_broadcast.sv */
`default_nettype none

module vector_operand_broadcast
    import vector_alu_pkg::*;
#(
    parameter int VLEN = 64
) (
    input  opsrc_e          opsrc_i,
    input  vsew_e           vsew_i,
    input  logic [VLEN-1:0] vs1_i,
    input  logic [XLEN-1:0] scalar_i,
    input  logic [4:0]      imm_i,
    output logic [VLEN-1:0] operand_b_o
);

    localparam int VLENB = VLEN / 8;

    logic [XLEN-1:0] scalar_elem;
    logic [VLEN-1:0] splat;

    // Immediate is sign-extended to full XLEN first,
    // so truncating to the element keeps the sign
    always_comb begin
        unique case (opsrc_i)
            SRC_VI:  scalar_elem = {{(XLEN-5){imm_i[4]}}, imm_i};
            default: scalar_elem = scalar_i;
        endcase
    end

    // Replicate the low element-width bits into every element
    always_comb begin
        unique case (vsew_i)
            EW8:     splat = {VLENB{scalar_elem[EW8_BITS-1:0]}};
            EW16:    splat = {(VLENB/2){scalar_elem[EW16_BITS-1:0]}};
            default: splat = {(VLENB/4){scalar_elem[EW32_BITS-1:0]}};
        endcase
    end

    always_comb begin
        unique case (opsrc_i)
            SRC_VV:  operand_b_o = vs1_i;
            default: operand_b_o = splat;
        endcase
    end

endmodule

`default_nettype wire

/* vector_alu_pkg.sv */
`default_nettype none

package vector_alu_pkg;

    // Scalar register width
    localparam int XLEN = 32;

    // Element sizes in bits
    localparam int EW8_BITS  = 8;
    localparam int EW16_BITS = 16;
    localparam int EW32_BITS = 32;

    typedef enum logic [4:0] {
        vadd, vsub, vrsub,
        vand, vor, vxor,
        vsll, vsrl, vsra,
        vmin, vminu, vmax, vmaxu,
        vmul, vmulh, vmulhu, vmulhsu
    } vec_op_e;

    typedef enum logic [1:0] {
        EW8  = 2'b00,
        EW16 = 2'b01,
        EW32 = 2'b10
    } vsew_e;

    // Where the second operand comes from
    typedef enum logic [1:0] {
        SRC_VV = 2'b00,
        SRC_VX = 2'b01,
        SRC_VI = 2'b10
    } opsrc_e;

    // Per-width index equal to log2 of element size in bytes
    function automatic logic [1:0] sew_log2_bytes(input vsew_e sew);
        unique case (sew)
            EW8:     return 2'd0;
            EW16:    return 2'd1;
            default: return 2'd2;
        endcase
    endfunction

endpackage

`default_nettype wire
